// ==== build.f ====
rtl/regFilePkg.sv
rtl/operandPkg.sv
rtl/regFile.sv
rtl/immExtend.sv
rtl/fetchControl.sv
rtl/operandFetch.sv
testbench/operandMonitor.sv
testbench/operandFetchTb.sv

// ==== rtl/fetchControl.sv ====
`timescale 1ns/1ps

module fetchControl
	import regFilePkg::*,
	operandPkg::*;
(
	input logic clk,
	input logic reset,

	// request channel
	input logic reqValid,
	output logic reqReady,
	input fetchReq req,

	// to storage and extender
	output readIndex idx,
	output logic [immWidth-1:0] immField,
	output immKind kind,

	// operands coming back
	input regData rs1,
	input regData rs2,
	input regData rs3,
	input regData imm,

	// response channel
	output logic respValid,
	input logic respReady,
	output fetchResp resp
);

	// a single response slot
	typedef enum logic
	{
		ctlEmpty,
		ctlFull
	} ctlState;

	ctlState state;
	ctlState nextState;
	logic accept;

	// request fields go straight to the datapath
	assign idx = req.idx;
	assign immField = req.immField;
	assign kind = req.kind;

	// slot frees up in the same cycle the response leaves
	assign reqReady = (state == ctlEmpty) || respReady;
	assign accept = reqValid && reqReady;
	assign respValid = (state == ctlFull);

	always_comb
	begin
		nextState = state;
		case (state)
			ctlEmpty:
			begin
				if (accept)
				begin
					nextState = ctlFull;
				end
			end
			ctlFull:
			begin
				if (accept)
				begin
					nextState = ctlFull;	// back-to-back
				end
				else if (respReady)
				begin
					nextState = ctlEmpty;
				end
			end
			default:
			begin
				nextState = ctlEmpty;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ctlEmpty;
		end
		else
		begin
			state <= nextState;
		end
	end

	// operands sampled at the accepting edge
	// held untouched while the consumer stalls
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			resp.rs1 <= rs1;
			resp.rs2 <= rs2;
			resp.rs3 <= rs3;
			resp.imm <= imm;
		end
	end

endmodule

// ==== rtl/immExtend.sv ====
`timescale 1ns/1ps

module immExtend
	import regFilePkg::*,
	operandPkg::*;
(
	input logic [immWidth-1:0] immField,
	input immKind kind,
	output regData imm
);

	// candidate results, one per kind
	regData shamtExt;
	regData byteExt;
	regData off12Ext;
	regData off13Ext;
	regData fullExt;
	regData branchExt;

	// shift amount is unsigned
	assign shamtExt =
	{
		{(dataWidth-shamtWidth){1'b0}},
		immField[shamtWidth-1:0]
	};

	assign byteExt =
	{
		{(dataWidth-byteWidth){immField[byteWidth-1]}},
		immField[byteWidth-1:0]
	};

	assign off12Ext =
	{
		{(dataWidth-off12Width){immField[off12Width-1]}},
		immField[off12Width-1:0]
	};

	assign off13Ext =
	{
		{(dataWidth-off13Width){immField[off13Width-1]}},
		immField[off13Width-1:0]
	};

	// whole field sign extended first
	assign fullExt =
	{
		{(dataWidth-immWidth){immField[immWidth-1]}},
		immField
	};

	// then scaled to a byte offset, top bits drop out
	assign branchExt = fullExt << branchShift;

	always_comb
	begin
		case (kind)
			immShamt5:
			begin
				imm = shamtExt;
			end
			immByte8:
			begin
				imm = byteExt;
			end
			immOff12:
			begin
				imm = off12Ext;
			end
			immOff13:
			begin
				imm = off13Ext;
			end
			immBranch18:
			begin
				imm = branchExt;
			end
			default:
			begin
				imm = '0;	// unused encodings
			end
		endcase
	end

endmodule

// ==== rtl/operandFetch.sv ====
`timescale 1ns/1ps

module operandFetch
	import regFilePkg::*,
	operandPkg::*;
(
	input logic clk,
	input logic reset,

	// write-back, always accepted
	input writeBack wb,

	// request channel
	input logic reqValid,
	output logic reqReady,
	input fetchReq req,

	// response channel
	output logic respValid,
	input logic respReady,
	output fetchResp resp
);

	readIndex readIdx;
	logic [immWidth-1:0] immField;
	immKind kind;

	regData rs1;
	regData rs2;
	regData rs3;
	regData imm;

	// handshakes and the response register
	fetchControl control
	(
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.req(req),
		.idx(readIdx),
		.immField(immField),
		.kind(kind),
		.rs1(rs1),
		.rs2(rs2),
		.rs3(rs3),
		.imm(imm),
		.respValid(respValid),
		.respReady(respReady),
		.resp(resp)
	);

	// 32 x 32 storage, reads are combinational
	regFile storage
	(
		.clk(clk),
		.reset(reset),
		.wb(wb),
		.idx(readIdx),
		.rs1(rs1),
		.rs2(rs2),
		.rs3(rs3)
	);

	immExtend extender
	(
		.immField(immField),
		.kind(kind),
		.imm(imm)
	);

endmodule

// ==== rtl/operandPkg.sv ====
package operandPkg;

	import regFilePkg::*;

	// raw immediate field as it comes with a request
	localparam int immWidth = 18;

	// widths of the narrower immediate forms
	localparam int shamtWidth = 5;
	localparam int byteWidth = 8;
	localparam int off12Width = 12;
	localparam int off13Width = 13;

	// word offset to byte offset
	localparam int branchShift = 2;

	typedef enum logic [2:0]
	{
		immShamt5,
		immByte8,
		immOff12,
		immOff13,
		immBranch18
	} immKind;

	// one read request
	typedef struct packed
	{
		readIndex idx;
		logic [immWidth-1:0] immField;
		immKind kind;
	} fetchReq;

	// operands handed on to the next stage
	typedef struct packed
	{
		regData rs1;
		regData rs2;
		regData rs3;
		regData imm;
	} fetchResp;

endpackage

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps

module regFile
	import regFilePkg::*;
(
	input logic clk,
	input logic reset,

	// write-back from the ALU and memory stages
	input writeBack wb,

	// read side
	input readIndex idx,
	output regData rs1,
	output regData rs2,
	output regData rs3
);

	regData regs [regCount];

	// one-hot write selects per port
	logic [regCount-1:0] aluHit;
	logic [regCount-1:0] memHit;

	// read indices and data as arrays so one loop serves all ports
	regIndex readSel [readPorts];
	regData readData [readPorts];

	always_comb
	begin
		aluHit = '0;
		if (wb.aluPort.enable)
		begin
			aluHit[wb.aluPort.dest] = 1'b1;
		end
	end

	always_comb
	begin
		memHit = '0;
		if (wb.memPort.enable)
		begin
			memHit[wb.memPort.dest] = 1'b1;
		end
	end

	// r0 is an ordinary register here
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < regCount; i++)
			begin
				if (memHit[i])
				begin
					regs[i] <= wb.memPort.data;	// memory wins a shared dest
				end
				else if (aluHit[i])
				begin
					regs[i] <= wb.aluPort.data;
				end
			end
		end
	end

	assign readSel[0] = idx.rs1Idx;
	assign readSel[1] = idx.rs2Idx;
	assign readSel[2] = idx.rs3Idx;

	// plain array reads, no bypass from the write ports
	genvar p;
	generate
		for (p = 0; p < readPorts; p++)
		begin : readPort
			assign readData[p] = regs[readSel[p]];
		end
	endgenerate

	assign rs1 = readData[0];
	assign rs2 = readData[1];
	assign rs3 = readData[2];

endmodule

// ==== rtl/regFilePkg.sv ====
package regFilePkg;

	// architectural sizes of the register file
	localparam int dataWidth = 32;
	localparam int regCount = 32;
	localparam int regIndexWidth = $clog2(regCount);

	// rs1, rs2 and rs3
	localparam int readPorts = 3;

	typedef logic [regIndexWidth-1:0] regIndex;
	typedef logic [dataWidth-1:0] regData;

	// a single write-back port
	typedef struct packed
	{
		logic enable;
		regIndex dest;
		regData data;
	} wbPort;

	// both write-back ports of one cycle
	typedef struct packed
	{
		wbPort aluPort;
		wbPort memPort;		// has priority on a shared dest
	} writeBack;

	// register numbers of the three read ports
	typedef struct packed
	{
		regIndex rs1Idx;
		regIndex rs2Idx;
		regIndex rs3Idx;
	} readIndex;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the operand-fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -f build.f --top-module operandFetchTb --Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see $logFile"
	exit 1
fi

if grep -qx "Result: PASSED" "$logFile"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $logFile"
	exit 1
fi

// ==== testbench/operandFetchTb.sv ====
`timescale 1ns/1ps

module operandFetchTb
	import regFilePkg::*,
	operandPkg::*;
();

	localparam int clkPeriod = 40;
	localparam int driveDelay = 2;
	localparam int resetCycles = 16;
	localparam int cyclesPerLine = 8;
	localparam int timeoutMargin = 100;
	localparam int drainLimit = 32;
	localparam string stimPath = "testbench/operand_stim.txt";

	logic clk;
	logic reset;
	writeBack wb;
	logic reqValid;
	logic reqReady;
	fetchReq req;
	logic respValid;
	logic respReady;
	fetchResp resp;

	logic expValid;
	fetchResp expResp;
	logic testEnd;
	int testNum;
	int pending;
	int errorCount;
	int testsPassed;
	int testsFailed;

	integer seed = 32'he031eb62;
	string lines [$];
	logic wbPending = 1'b0;	// a W line waiting for its edge
	int badLines = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	operandFetch operandFetch_i
	(
		.clk(clk),
		.reset(reset),
		.wb(wb),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.req(req),
		.respValid(respValid),
		.respReady(respReady),
		.resp(resp)
	);

	operandMonitor monitor
	(
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.respValid(respValid),
		.respReady(respReady),
		.resp(resp),
		.expValid(expValid),
		.expResp(expResp),
		.testEnd(testEnd),
		.testNum(testNum),
		.pending(pending),
		.errorCount(errorCount),
		.testsPassed(testsPassed),
		.testsFailed(testsFailed)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(clkPeriod/2) clk = ~clk;
		end
	end

	// random back-pressure on the response side
	initial
	begin
		logic [31:0] rnd;
		respReady = 1'b0;
		forever
		begin
			@(posedge clk);
			#driveDelay;
			rnd = $random(seed);
			respReady = !reset && rnd[0];
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic readStim(output bit ok);
		int fd;
		string line;
		fd = $fopen(stimPath, "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#")
				begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		ok = (lines.size() > 0);
	endtask

	// one edge, then the write ports go idle
	task automatic stepCycle();
		@(posedge clk);
		#driveDelay;
		if (wbPending)
		begin
			wb = '0;
			wbPending = 1'b0;
		end
	endtask

	task automatic reportBadLine(input string line);
		$display("stim line not understood: %s", line);
		badLines++;
	endtask

	task automatic runLine(input string line);
		logic [31:0] f [9];
		logic [7:0] op;
		int n;
		bit taken;
		int waited;
		op = line.getc(0);
		case (op)
			"W":
			begin
				n = $sscanf(line, "W %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
				if (n != 6)
				begin
					reportBadLine(line);
				end
				else
				begin
					if (wbPending)
					begin
						stepCycle();
					end
					wb.aluPort.enable = f[0][0];
					wb.aluPort.dest = f[1][4:0];
					wb.aluPort.data = f[2];
					wb.memPort.enable = f[3][0];
					wb.memPort.dest = f[4][4:0];
					wb.memPort.data = f[5];
					wbPending = 1'b1;
				end
			end
			"R":
			begin
				n = $sscanf(line, "R %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
					f[4], f[5], f[6], f[7], f[8]);
				if (n != 9)
				begin
					reportBadLine(line);
				end
				else
				begin
					req.idx.rs1Idx = f[0][4:0];
					req.idx.rs2Idx = f[1][4:0];
					req.idx.rs3Idx = f[2][4:0];
					req.immField = f[3][immWidth-1:0];
					req.kind = immKind'(f[4][2:0]);
					expResp.rs1 = f[5];
					expResp.rs2 = f[6];
					expResp.rs3 = f[7];
					expResp.imm = f[8];
					reqValid = 1'b1;
					expValid = 1'b1;
					do
					begin
						@(negedge clk);
						taken = reqReady;	// settled for the coming edge
						stepCycle();
					end
					while (!taken);
					reqValid = 1'b0;
					expValid = 1'b0;
				end
			end
			"T":
			begin
				n = $sscanf(line, "T %d", f[0]);
				if (n != 1)
				begin
					reportBadLine(line);
				end
				else
				begin
					if (wbPending)
					begin
						stepCycle();
					end
					waited = 0;
					while (pending != 0 && waited < drainLimit)
					begin
						stepCycle();
						waited++;
					end
					testNum = int'(f[0]);
					testEnd = 1'b1;
					stepCycle();
					testEnd = 1'b0;
				end
			end
			default:
			begin
				reportBadLine(line);
			end
		endcase
	endtask

	initial
	begin
		bit ok;
		reset = 1'b1;
		wb = '0;
		reqValid = 1'b0;
		req = '0;
		expValid = 1'b0;
		expResp = '0;
		testEnd = 1'b0;
		testNum = 0;
		readStim(ok);
		if (!ok)
		begin
			$display("could not read any stimulus from %s", stimPath);
			$display("Result: FAILED");
			$finish;
		end
		else
		begin
			cycleLimit = lines.size() * cyclesPerLine + resetCycles + timeoutMargin;
			repeat (resetCycles) @(posedge clk);
			#driveDelay;
			reset = 1'b0;
			foreach (lines[i])
			begin
				runLine(lines[i]);
			end
			if (wbPending)
			begin
				stepCycle();
			end
			$display("tests passed %0d, tests failed %0d, errors %0d, bad stim lines %0d",
				testsPassed, testsFailed, errorCount, badLines);
			if (badLines == 0 && errorCount == 0 && testsFailed == 0 && testsPassed > 0)
			begin
				$display("Result: PASSED");
			end
			else
			begin
				$display("Result: FAILED");
			end
			$finish;
		end
	end

endmodule

// ==== testbench/operandMonitor.sv ====
`timescale 1ns/1ps

module operandMonitor
	import regFilePkg::*,
	operandPkg::*;
(
	input logic clk,
	input logic reset,

	// DUT handshakes to watch
	input logic reqValid,
	input logic reqReady,
	input logic respValid,
	input logic respReady,
	input fetchResp resp,

	// expected response of the request on offer
	input logic expValid,
	input fetchResp expResp,

	input logic testEnd,
	input int testNum,

	output int pending,
	output int errorCount,
	output int testsPassed,
	output int testsFailed
);

	fetchResp expQueue [$];
	fetchResp heldResp;
	logic holding;
	logic acceptLast;	// request taken at the last edge
	int accepted = 0;
	int errorsAtStart = 0;

	task automatic checkField(input string name, input regData got, input regData want);
		if (got !== want)
		begin
			$display("mismatch at time %0d: %s is %h, expected %h", $time, name, got, want);
			errorCount++;
		end
	endtask

	task automatic takeResponse();
		fetchResp want;
		if (expQueue.size() == 0)
		begin
			$display("a response arrived at time %0d with no request outstanding", $time);
			errorCount++;
		end
		else
		begin
			want = expQueue.pop_front();
			checkField("rs1", resp.rs1, want.rs1);
			checkField("rs2", resp.rs2, want.rs2);
			checkField("rs3", resp.rs3, want.rs3);
			checkField("imm", resp.imm, want.imm);
		end
	endtask

	task automatic closeTest();
		if (expQueue.size() != 0)
		begin
			$display("test %0d: %0d response(s) never arrived", testNum, expQueue.size());
			errorCount += expQueue.size();
			expQueue.delete();
		end
		if (errorCount == errorsAtStart)
		begin
			$display("test %0d passed", testNum);
			testsPassed++;
		end
		else
		begin
			$display("test %0d failed with %0d error(s)", testNum, errorCount - errorsAtStart);
			testsFailed++;
		end
		errorsAtStart = errorCount;
	endtask

	// sampled mid-cycle where handshakes are settled for the coming edge
	always @(negedge clk)
	begin
		if (reset)
		begin
			holding = 1'b0;
			acceptLast = 1'b0;
		end
		else
		begin
			if (respValid && accepted == 0)
			begin
				$display("response valid at time %0d before any request", $time);
				errorCount++;
			end
			// ready whenever the slot is empty or being emptied
			if (reqReady !== (!respValid || respReady))
			begin
				$display("mismatch at time %0d: reqReady is %b, respValid %b, respReady %b",
					$time, reqReady, respValid, respReady);
				errorCount++;
			end
			if (acceptLast && !respValid)
			begin
				$display("mismatch at time %0d: %s", $time,
					"respValid low one cycle after acceptance");
				errorCount++;
			end
			if (holding && respValid && resp != heldResp)
			begin
				$display("mismatch at time %0d: held response changed while stalled", $time);
				errorCount++;
			end
			if (respValid && respReady)
			begin
				takeResponse();
			end
			holding = respValid && !respReady;
			heldResp = resp;
			acceptLast = reqValid && reqReady;
			if (expValid && reqValid && reqReady)
			begin
				expQueue.push_back(expResp);
				accepted++;
			end
			if (testEnd)
			begin
				closeTest();
			end
			pending = expQueue.size();
		end
	end

endmodule

// ==== testbench/operand_stim.txt ====
# W aluEn aluDest aluData memEn memDest memData (hex), driven together with the next line
# R rs1 rs2 rs3 immField kind(0 shamt5 1 byte8 2 off12 3 off13 4 branch18) rs1 rs2 rs3 imm; T test
R 00 05 1f 3ffff 0 00000000 00000000 00000000 0000001f
R 0a 0b 0c 00000 1 00000000 00000000 00000000 00000000
T 1
W 1 03 11111111 0 00 00000000
W 0 00 00000000 1 07 a5a5a5a5
W 1 1f deadbeef 0 00 00000000
R 03 07 00 00000 0 11111111 a5a5a5a5 00000000 00000000
R 1f 1f 1f 00000 0 deadbeef deadbeef deadbeef 00000000
T 2
W 1 04 01020304 1 05 05060708
W 1 06 aaaaaaaa 1 06 bbbbbbbb
R 04 05 06 00000 0 01020304 05060708 00000000 00000000
R 06 06 04 00000 0 bbbbbbbb bbbbbbbb 01020304 00000000
T 3
R 00 00 00 3ffe5 0 00000000 00000000 00000000 00000005
R 00 00 00 0007f 1 00000000 00000000 00000000 0000007f
R 00 00 00 3ff80 1 00000000 00000000 00000000 ffffff80
R 00 00 00 007ff 2 00000000 00000000 00000000 000007ff
R 00 00 00 00800 2 00000000 00000000 00000000 fffff800
R 00 00 00 00fff 3 00000000 00000000 00000000 00000fff
R 00 00 00 01000 3 00000000 00000000 00000000 fffff000
R 00 00 00 1ffff 4 00000000 00000000 00000000 0007fffc
R 00 00 00 20000 4 00000000 00000000 00000000 fff80000
R 00 00 00 3ffff 4 00000000 00000000 00000000 fffffffc
T 4
W 1 08 12345678 1 09 9abcdef0
W 1 0a 0badf00d 0 00 00000000
R 08 09 08 00000 1 12345678 9abcdef0 12345678 00000000
W 1 08 ffffffff 1 09 00000000
W 1 0b 0000000b 0 00 00000000
R 08 09 0a 3ffff 4 ffffffff 00000000 0badf00d fffffffc
R 0b 0b 0a 00800 3 0000000b 0000000b 0badf00d 00000800
R 03 04 05 00000 0 11111111 01020304 05060708 00000000
R 07 06 1f 3ff00 1 a5a5a5a5 bbbbbbbb deadbeef 00000000
T 5
W 1 0c cafef00d 0 00 00000000
R 0c 0c 0c 00000 0 00000000 00000000 00000000 00000000
R 0c 00 0c 0001f 2 cafef00d 00000000 cafef00d 0000001f
T 6
